// ==== all.f ====
logic/uart_cmd_pkg.sv
logic/payload_assembler.sv
logic/reply_sender.sv
logic/cmd_parser.sv
logic/uart_cmd_top.sv
testbench/uart_cmd_props.sv
testbench/uart_cmd_checker.sv
testbench/uart_cmd_tb.sv

// ==== testbench/uart_cmd_tb.sv ====
// Drives frames into uart_cmd_top with an EEPROM writer and UART TX model.
// Each frame waits for its reply before the next one starts.
// Random gaps, busy spans and ready drops come from one seeded $random.

module uart_cmd_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Long enough to cover a payload timeout plus back-pressure
    localparam int REPLY_WAIT = 2 * uart_cmd_pkg::RX_TIMEOUT_CYCLES + 500;

    logic        clk_sys;
    logic        rst_sys_n;
    logic        uart_rx_ren;
    logic [7:0]  uart_rx_rdata;
    logic        uart_tx_rdy;
    logic        e2p_busy;
    logic        wr_done;
    logic        uart_tx_wen;
    logic [7:0]  uart_tx_wdata;
    logic        wr_en;
    logic [15:0] wr_addr;
    logic [31:0] wr_value0;
    logic [31:0] wr_value1;
    logic [31:0] wr_value2;
    logic [31:0] wr_value3;
    logic        e2p_rw_sel;

    int         seed = 96522;
    logic       stress;
    logic [7:0] frame_q[$];
    int         assert_fails;

    uart_cmd_top dut_i (.*);

    uart_cmd_checker checker_i (
        .clk_sys       (clk_sys),
        .uart_tx_wen   (uart_tx_wen),
        .uart_tx_wdata (uart_tx_wdata),
        .uart_tx_rdy   (uart_tx_rdy),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_value0     (wr_value0),
        .wr_value1     (wr_value1),
        .wr_value2     (wr_value2),
        .wr_value3     (wr_value3),
        .e2p_busy      (e2p_busy),
        .e2p_rw_sel    (e2p_rw_sel)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [7:0] pick_data_fun();
        case (rand_below(3))
            0:       return uart_cmd_pkg::FUN_CH_CAL;
            1:       return uart_cmd_pkg::FUN_CON_CH_DATA;
            default: return uart_cmd_pkg::FUN_DATA_ACQ;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // EEPROM writer and UART transmitter models
    // ----------------------------------------------------------------------
    // wr_done pulses in the last cycle of a write's busy span
    initial begin : eeprom_writer
        int span;
        e2p_busy = 1'b0;
        wr_done  = 1'b0;
        forever begin
            @(negedge clk_sys);
            if (wr_en) begin
                span = 1 + rand_below(8);
                @(posedge clk_sys);
                e2p_busy <= 1'b1;
                repeat (span) @(posedge clk_sys);
                wr_done <= 1'b1;
                @(posedge clk_sys);
                wr_done  <= 1'b0;
                e2p_busy <= 1'b0;
            end else if (stress && rand_below(8) == 0) begin
                span = 5 + rand_below(36);
                @(posedge clk_sys);
                e2p_busy <= 1'b1;
                repeat (span) @(posedge clk_sys);
                e2p_busy <= 1'b0;
            end
        end
    end

    initial begin : tx_ready_model
        uart_tx_rdy = 1'b1;
        forever begin
            @(posedge clk_sys);
            if (stress) begin
                uart_tx_rdy <= 1'b0;
                repeat (1 + rand_below(30)) @(posedge clk_sys);
                uart_tx_rdy <= 1'b1;
                repeat (1 + rand_below(4)) @(posedge clk_sys);
            end else begin
                uart_tx_rdy <= (rand_below(4) != 0);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus tasks
    // ----------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic send_byte(input logic [7:0] b);
        repeat (rand_below(4)) @(posedge clk_sys);
        @(posedge clk_sys);
        uart_rx_ren   <= 1'b1;
        uart_rx_rdata <= b;
        @(posedge clk_sys);
        uart_rx_ren <= 1'b0;
    endtask

    task automatic start_frame(input logic [7:0] fun, input int junk);
        logic [7:0] b;
        frame_q.delete();
        repeat (junk) begin
            b = 8'(rand_below(256));
            if (b == uart_cmd_pkg::BOARD_ADDR) begin
                b = 8'h00;
            end
            frame_q.push_back(b);
        end
        frame_q.push_back(uart_cmd_pkg::BOARD_ADDR);
        frame_q.push_back(fun);
    endtask

    task automatic add_payload(input int n);
        repeat (n) frame_q.push_back(8'(rand_below(256)));
    endtask

    task automatic wait_reply(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk_sys);
        while (!uart_tx_wen && cycles < REPLY_WAIT) begin
            @(negedge clk_sys);
            cycles++;
        end
        if (!uart_tx_wen) begin
            abort_run($sformatf("Timeout: no reply byte for %s after %0d cycles", name, cycles));
        end else begin
            // Parser is back in idle two edges after the strobe
            repeat (2) @(posedge clk_sys);
        end
    endtask

    task automatic run_frame(input string name);
        checker_i.add_frame(name, frame_q);
        foreach (frame_q[i]) begin
            send_byte(frame_q[i]);
        end
        wait_reply(name);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin : main_seq
        rst_sys_n     = 1'b0;
        uart_rx_ren   = 1'b0;
        uart_rx_rdata = 8'h00;
        stress        = 1'b0;
        repeat (10) @(posedge clk_sys);
        rst_sys_n <= 1'b1;
        repeat (2) @(posedge clk_sys);

        start_frame(uart_cmd_pkg::FUN_CH_CAL, 2);
        run_frame("data_without_mode");
        start_frame(8'h20, 3);
        run_frame("unknown_function");
        start_frame(uart_cmd_pkg::FUN_CAL_ACQ, 1);
        run_frame("cal_acquire");

        start_frame(uart_cmd_pkg::FUN_CH_CAL, 0);
        add_payload(16);
        run_frame("ch_cal_write");
        start_frame(uart_cmd_pkg::FUN_CON_CH_DATA, 0);
        add_payload(16);
        run_frame("con_ch_data_write");
        start_frame(uart_cmd_pkg::FUN_DATA_ACQ, 0);
        add_payload(16);
        run_frame("data_acq_write");

        // Stalled payload, then a good frame
        start_frame(pick_data_fun(), 0);
        add_payload(rand_below(16));
        run_frame("payload_timeout");
        start_frame(uart_cmd_pkg::FUN_DATA_ACQ, 0);
        add_payload(16);
        run_frame("after_timeout");

        stress <= 1'b1;
        for (int i = 0; i < 6; i++) begin
            start_frame(pick_data_fun(), rand_below(3));
            add_payload(16);
            run_frame($sformatf("stress_%0d", i));
        end
        stress <= 1'b0;

        start_frame(uart_cmd_pkg::FUN_CAL_END, 2);
        run_frame("cal_end");
        start_frame(uart_cmd_pkg::FUN_DATA_ACQ, 0);
        run_frame("data_after_end");

        assert_fails = dut_i.parser_i.props_i.assert_fails;
        $display("Summary: %0d frames good, %0d frames failed, %0d assertion failures",
                 checker_i.pass_cnt, checker_i.fail_cnt, assert_fails);
        if (checker_i.fail_cnt == 0 && assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/uart_cmd_checker.sv ====
// Watches replies and EEPROM writes and compares them with a frame model.
// Expected results are queued by add_frame before the frame is sent.
// Assumes one frame in flight, each ending with exactly one reply byte.

module uart_cmd_checker (
    input logic         clk_sys,
    input logic         uart_tx_wen,
    input logic [7:0]   uart_tx_wdata,
    input logic         uart_tx_rdy,
    input logic         wr_en,
    input logic [15:0]  wr_addr,
    input logic [31:0]  wr_value0,
    input logic [31:0]  wr_value1,
    input logic [31:0]  wr_value2,
    input logic [31:0]  wr_value3,
    input logic         e2p_busy,
    input logic         e2p_rw_sel
);
    timeunit 1ns;
    timeprecision 1ps;

    int   pass_cnt   = 0;
    int   fail_cnt   = 0;
    logic model_mode = 1'b0;

    string        name_q[$];
    logic [7:0]   resp_q[$];
    logic         mode_q[$];
    logic         has_wr_q[$];
    logic [15:0]  addr_q[$];
    logic [127:0] words_q[$];
    logic [15:0]  seen_addr_q[$];
    logic [127:0] seen_words_q[$];

    // Words are packed as {word0, word1, word2, word3}
    function automatic logic [7:0] ref_reply(
        input  logic [7:0]   frame[$],
        inout  logic         mode,
        output logic         has_wr,
        output logic [15:0]  addr,
        output logic [127:0] words
    );
        int         pos;
        logic [7:0] fun;
        has_wr = 1'b0;
        addr   = '0;
        words  = '0;
        pos    = 0;
        // Bytes before the board address are ignored
        while (pos < frame.size() && frame[pos] != uart_cmd_pkg::BOARD_ADDR) begin
            pos++;
        end
        pos++;
        if (pos >= frame.size()) begin
            return uart_cmd_pkg::RESP_ERR;
        end
        fun = frame[pos];
        pos++;
        if (fun == uart_cmd_pkg::FUN_CAL_ACQ || fun == uart_cmd_pkg::FUN_CAL_END) begin
            mode = (fun == uart_cmd_pkg::FUN_CAL_ACQ);
            return uart_cmd_pkg::RESP_OK;
        end
        if (fun < uart_cmd_pkg::FUN_CH_CAL || fun > uart_cmd_pkg::FUN_DATA_ACQ || !mode) begin
            return uart_cmd_pkg::RESP_ERR;
        end
        // Short payload ends in a timeout
        if (frame.size() - pos < uart_cmd_pkg::PAYLOAD_BYTES) begin
            return uart_cmd_pkg::RESP_ERR;
        end
        has_wr = 1'b1;
        case (fun)
            uart_cmd_pkg::FUN_CH_CAL:      addr = uart_cmd_pkg::BASE_CH_CAL;
            uart_cmd_pkg::FUN_CON_CH_DATA: addr = uart_cmd_pkg::BASE_CON_CH_DATA;
            default:                       addr = uart_cmd_pkg::BASE_DATA_ACQ;
        endcase
        for (int k = 0; k < uart_cmd_pkg::PAYLOAD_BYTES; k++) begin
            words[127 - 8 * k -: 8] = frame[pos + k];
        end
        return uart_cmd_pkg::RESP_OK;
    endfunction

    task automatic add_frame(input string name, input logic [7:0] frame[$]);
        logic         has_wr;
        logic [15:0]  addr;
        logic [127:0] words;
        logic [7:0]   resp;
        resp = ref_reply(frame, model_mode, has_wr, addr, words);
        name_q.push_back(name);
        resp_q.push_back(resp);
        mode_q.push_back(model_mode);
        has_wr_q.push_back(has_wr);
        addr_q.push_back(addr);
        words_q.push_back(words);
    endtask

    // ----------------------------------------------------------------------
    // Monitors, sampled mid-cycle
    // ----------------------------------------------------------------------
    always @(negedge clk_sys) begin : record_writes
        if (wr_en) begin
            seen_addr_q.push_back(wr_addr);
            seen_words_q.push_back({wr_value0, wr_value1, wr_value2, wr_value3});
            if (e2p_busy) begin
                $display("Error: EEPROM write started while e2p_busy was high");
                fail_cnt++;
            end
        end
    end

    always @(negedge clk_sys) begin : compare_frame
        string        name;
        logic         ok;
        logic [7:0]   exp_resp;
        logic         exp_mode;
        logic         exp_wr;
        logic [15:0]  exp_addr;
        logic [127:0] exp_words;
        if (uart_tx_wen && name_q.size() == 0) begin
            $display("Error: reply byte %02h arrived with no frame outstanding", uart_tx_wdata);
            fail_cnt++;
        end else if (uart_tx_wen) begin
            name      = name_q.pop_front();
            exp_resp  = resp_q.pop_front();
            exp_mode  = mode_q.pop_front();
            exp_wr    = has_wr_q.pop_front();
            exp_addr  = addr_q.pop_front();
            exp_words = words_q.pop_front();
            ok        = 1'b1;
            if (!uart_tx_rdy) begin
                $display("Error in %s: reply strobe sent while uart_tx_rdy was low", name);
                ok = 1'b0;
            end
            if (uart_tx_wdata !== exp_resp) begin
                $display("Mismatch in %s: reply expected %02h, actual %02h",
                         name, exp_resp, uart_tx_wdata);
                ok = 1'b0;
            end
            if (e2p_rw_sel !== exp_mode) begin
                $display("Mismatch in %s: e2p_rw_sel expected %0b, actual %0b",
                         name, exp_mode, e2p_rw_sel);
                ok = 1'b0;
            end
            if (seen_addr_q.size() != (exp_wr ? 1 : 0)) begin
                $display("Mismatch in %s: EEPROM writes expected %0d, actual %0d",
                         name, exp_wr ? 1 : 0, seen_addr_q.size());
                ok = 1'b0;
            end else if (exp_wr && seen_addr_q[0] !== exp_addr) begin
                $display("Mismatch in %s: wr_addr expected %04h, actual %04h",
                         name, exp_addr, seen_addr_q[0]);
                ok = 1'b0;
            end else if (exp_wr && seen_words_q[0] !== exp_words) begin
                $display("Mismatch in %s: words expected %032h, actual %032h",
                         name, exp_words, seen_words_q[0]);
                ok = 1'b0;
            end
            seen_addr_q.delete();
            seen_words_q.delete();
            if (ok) begin
                pass_cnt++;
                $display("PASS  %s", name);
            end else begin
                fail_cnt++;
                $display("FAIL  %s", name);
            end
        end
    end

endmodule

// ==== testbench/uart_cmd_props.sv ====
// Protocol assertions for the frame FSM, bound into cmd_parser.
// Disabled while rst_sys_n is low; assert_fails counts every failure.

module uart_cmd_props (
    input logic clk_sys,
    input logic rst_sys_n,
    input logic wr_en,
    input logic e2p_busy,
    input logic resp_valid,
    input logic reply_busy
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;

    // Writes only start into an idle EEPROM writer
    wr_when_idle: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        wr_en |-> !e2p_busy)
        else begin
            assert_fails++;
            $error("wr_en asserted while e2p_busy is high");
        end

    wr_single: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        wr_en |=> !wr_en)
        else begin
            assert_fails++;
            $error("wr_en held for more than one cycle");
        end

    resp_single: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        resp_valid |=> !resp_valid)
        else begin
            assert_fails++;
            $error("resp_valid held for more than one cycle");
        end

    // Reply holding register has room for one byte only
    resp_free: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        resp_valid |-> !reply_busy)
        else begin
            assert_fails++;
            $error("resp_valid raised while a reply is still pending");
        end

endmodule

bind cmd_parser uart_cmd_props props_i (
    .clk_sys    (clk_sys),
    .rst_sys_n  (rst_sys_n),
    .wr_en      (wr_en),
    .e2p_busy   (e2p_busy),
    .resp_valid (resp_valid),
    .reply_busy (reply_busy)
);

// ==== logic/uart_cmd_top.sv ====
// Byte command front end between a UART pair and an EEPROM writer.
// One frame is handled at a time; each finished frame returns one reply byte.
// wr_addr and wr_value0..3 are valid while wr_en is high.

module uart_cmd_top (
    input  logic                              clk_sys,
    input  logic                              rst_sys_n,
    input  logic                              uart_rx_ren,
    input  logic [uart_cmd_pkg::BYTE_W-1:0]   uart_rx_rdata,
    input  logic                              uart_tx_rdy,
    input  logic                              e2p_busy,
    input  logic                              wr_done,
    output logic                              uart_tx_wen,
    output logic [uart_cmd_pkg::BYTE_W-1:0]   uart_tx_wdata,
    output logic                              wr_en,
    output logic [uart_cmd_pkg::ADDR_W-1:0]   wr_addr,
    output logic [uart_cmd_pkg::WORD_W-1:0]   wr_value0,
    output logic [uart_cmd_pkg::WORD_W-1:0]   wr_value1,
    output logic [uart_cmd_pkg::WORD_W-1:0]   wr_value2,
    output logic [uart_cmd_pkg::WORD_W-1:0]   wr_value3,
    output logic                              e2p_rw_sel
);

    logic                     pay_capture;
    logic                     pay_clear;
    logic                     pay_full;
    logic                     resp_valid;
    uart_cmd_pkg::resp_code_e resp_code;
    logic                     reply_busy;

    cmd_parser parser_i (
        .clk_sys       (clk_sys),
        .rst_sys_n     (rst_sys_n),
        .uart_rx_ren   (uart_rx_ren),
        .uart_rx_rdata (uart_rx_rdata),
        .pay_full      (pay_full),
        .e2p_busy      (e2p_busy),
        .wr_done       (wr_done),
        .reply_busy    (reply_busy),
        .pay_capture   (pay_capture),
        .pay_clear     (pay_clear),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .e2p_rw_sel    (e2p_rw_sel),
        .resp_valid    (resp_valid),
        .resp_code     (resp_code)
    );

    // Payload bytes come straight off the receive bus
    payload_assembler payload_i (
        .clk_sys       (clk_sys),
        .rst_sys_n     (rst_sys_n),
        .pay_capture   (pay_capture),
        .pay_clear     (pay_clear),
        .uart_rx_rdata (uart_rx_rdata),
        .pay_full      (pay_full),
        .wr_value0     (wr_value0),
        .wr_value1     (wr_value1),
        .wr_value2     (wr_value2),
        .wr_value3     (wr_value3)
    );

    reply_sender reply_i (
        .clk_sys       (clk_sys),
        .rst_sys_n     (rst_sys_n),
        .resp_valid    (resp_valid),
        .resp_code     (resp_code),
        .uart_tx_rdy   (uart_tx_rdy),
        .reply_busy    (reply_busy),
        .uart_tx_wen   (uart_tx_wen),
        .uart_tx_wdata (uart_tx_wdata)
    );

endmodule

// ==== logic/cmd_parser.sv ====
// Frame FSM for the byte command protocol.
// Data commands are accepted only while calibration mode is on.
// One shared timer covers byte gaps and the wait for wr_done.

module cmd_parser (
    input  logic                              clk_sys,
    input  logic                              rst_sys_n,
    input  logic                              uart_rx_ren,
    input  logic [uart_cmd_pkg::BYTE_W-1:0]   uart_rx_rdata,
    input  logic                              pay_full,
    input  logic                              e2p_busy,
    input  logic                              wr_done,
    input  logic                              reply_busy,
    output logic                              pay_capture,
    output logic                              pay_clear,
    output logic                              wr_en,
    output logic [uart_cmd_pkg::ADDR_W-1:0]   wr_addr,
    output logic                              e2p_rw_sel,
    output logic                              resp_valid,
    output uart_cmd_pkg::resp_code_e          resp_code
);

    localparam logic [uart_cmd_pkg::TIMER_W-1:0] TIMEOUT_LAST =
        uart_cmd_pkg::TIMER_W'(uart_cmd_pkg::RX_TIMEOUT_CYCLES - 1);

    uart_cmd_pkg::parser_state_e state;
    uart_cmd_pkg::parser_state_e state_nxt;
    uart_cmd_pkg::fun_code_e     fun_q;

    logic [uart_cmd_pkg::TIMER_W-1:0] timer;
    logic timer_run;
    logic timeout;
    logic cal_mode;
    logic mode_set;
    logic mode_clr;
    logic fun_load;
    logic resp_fire;
    logic resp_ok;

    assign e2p_rw_sel = cal_mode;

    // ----------------------------------------------------------------------
    // Timeout timer, restarts on state entry and on every payload byte
    // ----------------------------------------------------------------------
    assign timer_run = (state == uart_cmd_pkg::ST_FUN_SEL) ||
                       (state == uart_cmd_pkg::ST_PAYLOAD) ||
                       (state == uart_cmd_pkg::ST_WAIT_DONE);
    assign timeout   = timer_run && (timer == TIMEOUT_LAST);

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            timer <= '0;
        end else if (!timer_run || (state_nxt != state) || pay_capture) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Next state and per-cycle strobes
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt   = state;
        pay_capture = 1'b0;
        pay_clear   = 1'b0;
        wr_en       = 1'b0;
        mode_set    = 1'b0;
        mode_clr    = 1'b0;
        fun_load    = 1'b0;
        resp_fire   = 1'b0;
        resp_ok     = 1'b0;
        case (state)
            uart_cmd_pkg::ST_IDLE: begin
                if (uart_rx_ren && uart_rx_rdata == uart_cmd_pkg::BOARD_ADDR) begin
                    state_nxt = uart_cmd_pkg::ST_FUN_SEL;
                end
            end
            uart_cmd_pkg::ST_FUN_SEL: begin
                if (uart_rx_ren) begin
                    // Default outcome is an error reply
                    state_nxt = uart_cmd_pkg::ST_REPLY;
                    resp_fire = 1'b1;
                    case (uart_rx_rdata)
                        uart_cmd_pkg::FUN_CAL_ACQ: begin
                            mode_set = 1'b1;
                            resp_ok  = 1'b1;
                        end
                        uart_cmd_pkg::FUN_CAL_END: begin
                            mode_clr = 1'b1;
                            resp_ok  = 1'b1;
                        end
                        uart_cmd_pkg::FUN_CH_CAL,
                        uart_cmd_pkg::FUN_CON_CH_DATA,
                        uart_cmd_pkg::FUN_DATA_ACQ: begin
                            if (cal_mode) begin
                                fun_load  = 1'b1;
                                resp_fire = 1'b0;
                                state_nxt = uart_cmd_pkg::ST_PAYLOAD;
                            end
                        end
                        default: begin
                        end
                    endcase
                end else if (timeout) begin
                    resp_fire = 1'b1;
                    state_nxt = uart_cmd_pkg::ST_REPLY;
                end
            end
            uart_cmd_pkg::ST_PAYLOAD: begin
                pay_capture = uart_rx_ren && !pay_full;
                if (pay_full) begin
                    state_nxt = uart_cmd_pkg::ST_WRITE;
                end else if (timeout && !uart_rx_ren) begin
                    // Stalled payload, drop it without writing
                    pay_clear = 1'b1;
                    resp_fire = 1'b1;
                    state_nxt = uart_cmd_pkg::ST_REPLY;
                end
            end
            uart_cmd_pkg::ST_WRITE: begin
                if (!e2p_busy) begin
                    wr_en     = 1'b1;
                    state_nxt = uart_cmd_pkg::ST_WAIT_DONE;
                end
            end
            uart_cmd_pkg::ST_WAIT_DONE: begin
                if (wr_done) begin
                    resp_fire = 1'b1;
                    resp_ok   = 1'b1;
                    state_nxt = uart_cmd_pkg::ST_REPLY;
                end else if (timeout) begin
                    resp_fire = 1'b1;
                    state_nxt = uart_cmd_pkg::ST_REPLY;
                end
            end
            uart_cmd_pkg::ST_REPLY: begin
                // reply_busy rises one cycle after resp_valid
                if (!resp_valid && !reply_busy) begin
                    state_nxt = uart_cmd_pkg::ST_IDLE;
                end
            end
            default: begin
                state_nxt = uart_cmd_pkg::ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Control registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            state      <= uart_cmd_pkg::ST_IDLE;
            cal_mode   <= 1'b0;
            resp_valid <= 1'b0;
            wr_addr    <= '0;
        end else begin
            state      <= state_nxt;
            resp_valid <= resp_fire;
            if (mode_set) begin
                cal_mode <= 1'b1;
            end else if (mode_clr) begin
                cal_mode <= 1'b0;
            end
            // Address is fixed once the payload is complete
            if (state == uart_cmd_pkg::ST_PAYLOAD && pay_full) begin
                case (fun_q)
                    uart_cmd_pkg::FUN_CON_CH_DATA: wr_addr <= uart_cmd_pkg::BASE_CON_CH_DATA;
                    uart_cmd_pkg::FUN_DATA_ACQ:    wr_addr <= uart_cmd_pkg::BASE_DATA_ACQ;
                    default:                       wr_addr <= uart_cmd_pkg::BASE_CH_CAL;
                endcase
            end
        end
    end

    // Function code and reply byte
    always_ff @(posedge clk_sys) begin
        if (fun_load) begin
            fun_q <= uart_cmd_pkg::fun_code_e'(uart_rx_rdata);
        end
        if (resp_fire) begin
            resp_code <= resp_ok ? uart_cmd_pkg::RESP_OK : uart_cmd_pkg::RESP_ERR;
        end
    end

endmodule

// ==== logic/reply_sender.sv ====
// Holds one reply byte until the UART transmitter is ready.
// A new resp_valid is expected only after reply_busy has fallen.

module reply_sender (
    input  logic                              clk_sys,
    input  logic                              rst_sys_n,
    input  logic                              resp_valid,
    input  uart_cmd_pkg::resp_code_e          resp_code,
    input  logic                              uart_tx_rdy,
    output logic                              reply_busy,
    output logic                              uart_tx_wen,
    output logic [uart_cmd_pkg::BYTE_W-1:0]   uart_tx_wdata
);

    logic [uart_cmd_pkg::BYTE_W-1:0] tx_byte;

    // ----------------------------------------------------------------------
    // Pending flag
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            reply_busy <= 1'b0;
        end else if (resp_valid) begin
            reply_busy <= 1'b1;
        end else if (uart_tx_wen) begin
            reply_busy <= 1'b0;
        end
    end

    // Reply byte, captured with resp_valid
    always_ff @(posedge clk_sys) begin
        if (resp_valid) begin
            tx_byte <= resp_code;
        end
    end

    // Strobe goes out in the same cycle the transmitter reports ready
    assign uart_tx_wen   = reply_busy && uart_tx_rdy;
    assign uart_tx_wdata = tx_byte;

endmodule

// ==== logic/payload_assembler.sv ====
// Packs 16 payload bytes into four 32-bit words, first byte of a word on top.
// Words keep their value until the next payload overwrites them.

module payload_assembler (
    input  logic                              clk_sys,
    input  logic                              rst_sys_n,
    input  logic                              pay_capture,
    input  logic                              pay_clear,
    input  logic [uart_cmd_pkg::BYTE_W-1:0]   uart_rx_rdata,
    output logic                              pay_full,
    output logic [uart_cmd_pkg::WORD_W-1:0]   wr_value0,
    output logic [uart_cmd_pkg::WORD_W-1:0]   wr_value1,
    output logic [uart_cmd_pkg::WORD_W-1:0]   wr_value2,
    output logic [uart_cmd_pkg::WORD_W-1:0]   wr_value3
);

    localparam logic [uart_cmd_pkg::PAY_CNT_W-1:0] LAST_BYTE =
        uart_cmd_pkg::PAY_CNT_W'(uart_cmd_pkg::PAYLOAD_BYTES - 1);

    logic [uart_cmd_pkg::PAY_CNT_W-1:0] byte_cnt;
    logic [uart_cmd_pkg::WORD_W-1:0]    words [4];
    logic [1:0]                         word_sel;

    // Four bytes per word
    assign word_sel = byte_cnt[3:2];

    // ----------------------------------------------------------------------
    // Byte count and full pulse
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            byte_cnt <= '0;
            pay_full <= 1'b0;
        end else begin
            pay_full <= 1'b0;
            if (pay_clear) begin
                byte_cnt <= '0;
            end else if (pay_capture) begin
                if (byte_cnt == LAST_BYTE) begin
                    byte_cnt <= '0;
                    pay_full <= 1'b1;
                end else begin
                    byte_cnt <= byte_cnt + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Word packing, shift left so the first byte ends up as the MSB
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            for (int i = 0; i < 4; i++) begin
                words[i] <= '0;
            end
        end else if (pay_capture && !pay_clear) begin
            words[word_sel] <= {words[word_sel][uart_cmd_pkg::WORD_W-uart_cmd_pkg::BYTE_W-1:0],
                                uart_rx_rdata};
        end
    end

    assign wr_value0 = words[0];
    assign wr_value1 = words[1];
    assign wr_value2 = words[2];
    assign wr_value3 = words[3];

endmodule

// ==== logic/uart_cmd_pkg.sv ====
// Shared codes and sizes for the UART command front end.
// The board address and EEPROM base addresses are fixed at build time.
// RX_TIMEOUT_CYCLES must fit in TIMER_W bits.

package uart_cmd_pkg;

    // ----------------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------------
    localparam int BYTE_W        = 8;
    localparam int WORD_W        = 32;
    localparam int ADDR_W        = 16;
    localparam int PAY_CNT_W     = 5;
    localparam int PAYLOAD_BYTES = 16;

    // Frame timing
    localparam int TIMER_W           = 11;
    localparam int RX_TIMEOUT_CYCLES = 2000;

    localparam logic [BYTE_W-1:0] BOARD_ADDR = 8'h10;

    // EEPROM base address per data command
    localparam logic [ADDR_W-1:0] BASE_CH_CAL      = 16'h0000;
    localparam logic [ADDR_W-1:0] BASE_CON_CH_DATA = 16'h0100;
    localparam logic [ADDR_W-1:0] BASE_DATA_ACQ    = 16'h0200;

    // ----------------------------------------------------------------------
    // Byte codes
    // ----------------------------------------------------------------------
    typedef enum logic [BYTE_W-1:0] {
        FUN_CAL_ACQ     = 8'h31,
        FUN_CH_CAL      = 8'h32,
        FUN_CON_CH_DATA = 8'h33,
        FUN_DATA_ACQ    = 8'h34,
        FUN_CAL_END     = 8'h35
    } fun_code_e;

    typedef enum logic [BYTE_W-1:0] {
        RESP_OK  = 8'h4F,
        RESP_ERR = 8'h45
    } resp_code_e;

    // Frame FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FUN_SEL,
        ST_PAYLOAD,
        ST_WRITE,
        ST_WAIT_DONE,
        ST_REPLY
    } parser_state_e;

endpackage
